// ==== tpu_pkg.sv ====
package tpu_pkg;

    // edge of the square array
    // buffer word packing depends on it
    localparam int array_dim = 4;

    // element and accumulator widths
    localparam int elem_bits = 8;
    localparam int acc_bits = 32;

    // one signed operand
    typedef logic signed [elem_bits-1:0] elem_t;

    // running sum and result element
    typedef logic signed [acc_bits-1:0] acc_t;

    // A or B buffer word, lane 0 in the top byte
    typedef logic [array_dim*elem_bits-1:0] word_t;

    // result row for C, column 0 in the top 32 bits
    typedef logic [array_dim*acc_bits-1:0] c_row_t;

    // job size (K, M or N) or tile count
    typedef logic [7:0] dim_t;

    // in-tile step counter
    typedef logic [15:0] step_t;

    // sequencer phase
    // read streams operands, write drains rows to C
    typedef enum logic [1:0] {
        idle   = 2'd0,
        read   = 2'd1,
        write  = 2'd2,
        finish = 2'd3
    } phase_e;

endpackage

// ==== job_if.sv ====
interface job_if;

    // latched job description
    tpu_pkg::dim_t k_len;
    tpu_pkg::dim_t m_tiles;
    tpu_pkg::dim_t n_tiles;

    // rows written by the last block of A, 1 to array_dim
    logic [$clog2(tpu_pkg::array_dim):0] last_rows;

    // one-cycle kick and the running level
    logic start;
    logic busy;

    modport cfg(output k_len, m_tiles, n_tiles, last_rows, start, input busy);

    modport seq(input k_len, m_tiles, n_tiles, last_rows, start, output busy);

endinterface

// ==== array_ctrl_if.sv ====
interface array_ctrl_if;

    // current sequencer phase
    tpu_pkg::phase_e phase;

    // high when buffer data for a valid step is on the bus
    logic feed;

    // psum row picked for the C write
    logic [$clog2(tpu_pkg::array_dim)-1:0] row_sel;

    // packed result row coming back from the array
    tpu_pkg::c_row_t c_row;

    modport seq(output phase, feed, row_sel, input c_row);

    modport loader(input phase, feed);

    modport array(input phase, row_sel, output c_row);

endinterface

// ==== job_config.sv ====
module job_config (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid,
    input  tpu_pkg::dim_t k,
    input  tpu_pkg::dim_t m,
    input  tpu_pkg::dim_t n,
    job_if.cfg            job
);

    localparam int shift = $clog2(tpu_pkg::array_dim);

    tpu_pkg::dim_t k_q;
    tpu_pkg::dim_t m_q;
    tpu_pkg::dim_t n_q;
    logic          start_q;
    logic          accept;

    // a request is dropped while a job runs or is about to start
    assign accept = in_valid && !job.busy && !start_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_q <= 1'b0;
            k_q <= '0;
            m_q <= '0;
            n_q <= '0;
        end else begin
            start_q <= accept;
            if (accept) begin
                k_q <= k;
                m_q <= m;
                n_q <= n;
            end
        end
    end

    assign job.start = start_q;
    assign job.k_len = k_q;

    // ceiling of size / array_dim
    assign job.m_tiles = (m_q >> shift) + tpu_pkg::dim_t'(m_q[shift-1:0] != '0);
    assign job.n_tiles = (n_q >> shift) + tpu_pkg::dim_t'(n_q[shift-1:0] != '0);

    // a full last block writes every row
    assign job.last_rows = (m_q[shift-1:0] == '0) ? (shift+1)'(tpu_pkg::array_dim)
                                                  : {1'b0, m_q[shift-1:0]};

endmodule

// ==== tile_sequencer.sv ====
module tile_sequencer #(
    parameter int addr_bits = 12
) (
    input  logic                 clk,
    input  logic                 rst_n,
    job_if.seq                   job,
    array_ctrl_if.seq            ctl,
    output logic [addr_bits-1:0] a_index,
    output logic [addr_bits-1:0] b_index,
    output logic [addr_bits-1:0] c_index,
    output logic                 c_wr_en,
    output tpu_pkg::c_row_t      c_data_in
);

    localparam int row_bits = $clog2(tpu_pkg::array_dim);

    // skew on both edges plus the hops across the grid
    localparam int drain_steps = 2 * (tpu_pkg::array_dim - 1);

    tpu_pkg::phase_e      phase;
    tpu_pkg::phase_e      phase_nxt;
    tpu_pkg::step_t       step;
    logic [row_bits-1:0]  row;
    tpu_pkg::dim_t        mb;
    tpu_pkg::dim_t        nb;
    logic [addr_bits-1:0] a_base;
    logic [addr_bits-1:0] b_base;
    logic [row_bits:0]    tile_rows;
    logic                 prefetch;
    logic                 read_done;
    logic                 tile_done;
    logic                 last_mb;
    logic                 last_nb;
    logic                 feed_q;
    logic                 busy_q;

    assign last_mb = (mb == job.m_tiles - 8'd1);
    assign last_nb = (nb == job.n_tiles - 8'd1);

    // only the last block of A can be short
    assign tile_rows = last_mb ? job.last_rows : (row_bits+1)'(tpu_pkg::array_dim);

    assign prefetch = (phase == tpu_pkg::read) && (step < tpu_pkg::step_t'(job.k_len));

    // last read cycle holds the final product of the corner cell
    assign read_done = (phase == tpu_pkg::read)
                    && (step == tpu_pkg::step_t'(job.k_len) + tpu_pkg::step_t'(drain_steps));

    assign tile_done = (phase == tpu_pkg::write) && ({1'b0, row} == tile_rows - 1'b1);

    always_comb begin
        phase_nxt = phase;
        case (phase)
            tpu_pkg::idle: begin
                if (job.start || busy_q) begin
                    phase_nxt = tpu_pkg::read;
                end
            end
            tpu_pkg::read: begin
                if (read_done) begin
                    phase_nxt = tpu_pkg::write;
                end
            end
            tpu_pkg::write: begin
                if (tile_done) begin
                    phase_nxt = (last_mb && last_nb) ? tpu_pkg::finish : tpu_pkg::idle;
                end
            end
            default: begin
                phase_nxt = tpu_pkg::idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= tpu_pkg::idle;
            step <= '0;
            row <= '0;
            feed_q <= 1'b0;
            busy_q <= 1'b0;
        end else begin
            phase <= phase_nxt;
            // data shows up one cycle after its index
            feed_q <= prefetch;
            step <= (phase == tpu_pkg::read && !read_done) ? step + 1'b1 : '0;
            row <= (phase == tpu_pkg::write && !tile_done) ? row + 1'b1 : '0;
            if (job.start) begin
                busy_q <= 1'b1;
            end else if (tile_done && last_mb && last_nb) begin
                busy_q <= 1'b0;
            end
        end
    end

    // A block moves fastest, B block wraps last
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mb <= '0;
            nb <= '0;
            a_base <= '0;
            b_base <= '0;
            c_index <= '0;
        end else begin
            if (phase == tpu_pkg::finish || job.start) begin
                c_index <= '0;
            end else if (c_wr_en) begin
                c_index <= c_index + 1'b1;
            end
            if (tile_done) begin
                if (last_mb) begin
                    mb <= '0;
                    a_base <= '0;
                    if (last_nb) begin
                        nb <= '0;
                        b_base <= '0;
                    end else begin
                        nb <= nb + 8'd1;
                        b_base <= b_base + addr_bits'(job.k_len);
                    end
                end else begin
                    mb <= mb + 8'd1;
                    a_base <= a_base + addr_bits'(job.k_len);
                end
            end
        end
    end

    assign a_index = prefetch ? a_base + addr_bits'(step) : '0;
    assign b_index = prefetch ? b_base + addr_bits'(step) : '0;

    assign c_wr_en = (phase == tpu_pkg::write);
    assign c_data_in = ctl.c_row;

    assign ctl.phase = phase;
    assign ctl.feed = feed_q;
    assign ctl.row_sel = row;

    assign job.busy = busy_q;

endmodule

// ==== skew_loader.sv ====
module skew_loader (
    input  logic           clk,
    input  logic           rst_n,
    input  tpu_pkg::word_t data,
    array_ctrl_if.loader   ctl,
    output tpu_pkg::word_t lanes
);

    localparam int dim = tpu_pkg::array_dim;
    localparam int eb = tpu_pkg::elem_bits;

    tpu_pkg::word_t gated;

    // zeros once the steps run out so the tail drains
    assign gated = ctl.feed ? data : '0;

    // lane 0 goes straight in
    assign lanes[(dim-1)*eb +: eb] = gated[(dim-1)*eb +: eb];

    for (genvar i = 1; i < dim; i++) begin : g_lane
        // i bytes deep, newest byte at the bottom
        logic [i*eb-1:0] chain;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                chain <= '0;
            end else if (ctl.phase == tpu_pkg::idle) begin
                chain <= '0;
            end else begin
                chain <= (i*eb)'({chain, gated[(dim-1-i)*eb +: eb]});
            end
        end

        // oldest byte leaves after i cycles
        assign lanes[(dim-1-i)*eb +: eb] = chain[i*eb-1 -: eb];
    end

endmodule

// ==== mac_pe.sv ====
module mac_pe (
    input  logic            clk,
    input  logic            rst_n,
    input  tpu_pkg::phase_e phase,
    input  tpu_pkg::elem_t  west,
    input  tpu_pkg::elem_t  north,
    output tpu_pkg::elem_t  east,
    output tpu_pkg::elem_t  south,
    output tpu_pkg::acc_t   psum
);

    tpu_pkg::acc_t product;

    // both operands signed, so the product sign-extends
    assign product = west * north;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psum <= '0;
            east <= '0;
            south <= '0;
        end else if (phase == tpu_pkg::idle) begin
            // fresh tile
            psum <= '0;
            east <= '0;
            south <= '0;
        end else if (phase == tpu_pkg::read) begin
            psum <= psum + product;
            east <= west;
            south <= north;
        end
    end

endmodule

// ==== systolic_array.sv ====
module systolic_array (
    input  logic           clk,
    input  logic           rst_n,
    input  tpu_pkg::word_t row_lanes,
    input  tpu_pkg::word_t col_lanes,
    array_ctrl_if.array    ctl
);

    localparam int dim = tpu_pkg::array_dim;
    localparam int eb = tpu_pkg::elem_bits;
    localparam int ab = tpu_pkg::acc_bits;

    // operand links, one extra column and row past the grid edge
    tpu_pkg::elem_t  h_link [dim][dim+1];
    tpu_pkg::elem_t  v_link [dim+1][dim];
    tpu_pkg::acc_t   psum   [dim][dim];
    tpu_pkg::c_row_t row_word;

    for (genvar e = 0; e < dim; e++) begin : g_edge
        assign h_link[e][0] = row_lanes[(dim-1-e)*eb +: eb];
        assign v_link[0][e] = col_lanes[(dim-1-e)*eb +: eb];
    end

    // A flows east, B flows south
    for (genvar r = 0; r < dim; r++) begin : g_row
        for (genvar c = 0; c < dim; c++) begin : g_col
            mac_pe u_pe (
                .clk   (clk),
                .rst_n (rst_n),
                .phase (ctl.phase),
                .west  (h_link[r][c]),
                .north (v_link[r][c]),
                .east  (h_link[r][c+1]),
                .south (v_link[r+1][c]),
                .psum  (psum[r][c])
            );
        end
    end

    // column 0 lands in the top word
    always_comb begin
        for (int j = 0; j < dim; j++) begin
            row_word[(dim-1-j)*ab +: ab] = psum[ctl.row_sel][j];
        end
    end

    assign ctl.c_row = row_word;

endmodule

// ==== tpu_top.sv ====
module tpu_top #(
    parameter int addr_bits = 12
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  tpu_pkg::dim_t        k,
    input  tpu_pkg::dim_t        m,
    input  tpu_pkg::dim_t        n,
    input  tpu_pkg::word_t       a_data_out,
    input  tpu_pkg::word_t       b_data_out,
    output logic                 busy,
    output logic [addr_bits-1:0] a_index,
    output logic [addr_bits-1:0] b_index,
    output logic                 c_wr_en,
    output logic [addr_bits-1:0] c_index,
    output tpu_pkg::c_row_t      c_data_in
);

    job_if        job ();
    array_ctrl_if ctl ();

    // skewed operands into the west and north edges
    tpu_pkg::word_t a_lanes;
    tpu_pkg::word_t b_lanes;

    assign busy = job.busy;

    job_config u_job_config (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .k        (k),
        .m        (m),
        .n        (n),
        .job      (job)
    );

    tile_sequencer #(
        .addr_bits (addr_bits)
    ) u_tile_sequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .job       (job),
        .ctl       (ctl),
        .a_index   (a_index),
        .b_index   (b_index),
        .c_index   (c_index),
        .c_wr_en   (c_wr_en),
        .c_data_in (c_data_in)
    );

    // rows of A
    skew_loader u_a_loader (
        .clk   (clk),
        .rst_n (rst_n),
        .data  (a_data_out),
        .ctl   (ctl),
        .lanes (a_lanes)
    );

    // columns of B
    skew_loader u_b_loader (
        .clk   (clk),
        .rst_n (rst_n),
        .data  (b_data_out),
        .ctl   (ctl),
        .lanes (b_lanes)
    );

    systolic_array u_systolic_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .row_lanes (a_lanes),
        .col_lanes (b_lanes),
        .ctl       (ctl)
    );

endmodule

// ==== tpu_chk.sv ====
module tpu_chk #(
    parameter int addr_bits = 12
) (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 busy,
    input logic                 c_wr_en,
    input logic [addr_bits-1:0] c_index
);
    timeunit 1ns;
    timeprecision 1ps;

    // C writes only happen inside a job
    a_write_in_job: assert property (@(posedge clk) disable iff (!rst_n)
        c_wr_en |-> busy)
        else $error("c_wr_en high while busy is low");

    // busy drops only after the last write has gone out
    a_busy_after_write: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> !c_wr_en)
        else $error("busy fell in a write cycle");

    // each write moves the index on by one
    a_index_step: assert property (@(posedge clk) disable iff (!rst_n)
        $past(c_wr_en) |-> c_index == $past(c_index) + 1'b1)
        else $error("c_index did not advance by one after a write");

    // between tiles of one job the index holds
    a_index_hold: assert property (@(posedge clk) disable iff (!rst_n)
        busy && $past(busy) && !$past(c_wr_en) |-> $stable(c_index))
        else $error("c_index changed without a write");

endmodule

// ==== tb_tpu.sv ====
module tb_tpu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int addr_bits = 12;
    localparam int dim = tpu_pkg::array_dim;
    localparam int depth = 1 << addr_bits;
    localparam int ncases = 5;

    // case table with sizes, the extreme operand flag and the mid-job in_valid pulse flag
    string name_tab [ncases] = '{"single_tile", "multi_tile", "signed_extremes",
                                 "valid_while_busy", "narrow_job"};
    localparam int k_tab     [ncases] = '{1, 9, 16, 5, 3};
    localparam int m_tab     [ncases] = '{4, 10, 8, 6, 3};
    localparam int n_tab     [ncases] = '{4, 8, 4, 5, 7};
    localparam int ext_tab   [ncases] = '{0, 0, 1, 0, 0};
    localparam int pulse_tab [ncases] = '{0, 0, 0, 1, 0};

    logic                 clk = 1'b0;
    logic                 rst_n = 1'b0;
    logic                 in_valid = 1'b0;
    tpu_pkg::dim_t        k = '0;
    tpu_pkg::dim_t        m = '0;
    tpu_pkg::dim_t        n = '0;
    tpu_pkg::word_t       a_data_out = '0;
    tpu_pkg::word_t       b_data_out = '0;
    logic                 busy;
    logic [addr_bits-1:0] a_index;
    logic [addr_bits-1:0] b_index;
    logic [addr_bits-1:0] c_index;
    logic                 c_wr_en;
    tpu_pkg::c_row_t      c_data_in;

    tpu_pkg::word_t  a_mem [depth];
    tpu_pkg::word_t  b_mem [depth];
    tpu_pkg::c_row_t c_mem [depth];
    int              a_el [64][64];
    int              b_el [64][64];
    int              value_errs = 0;
    int              proto_errs = 0;
    int              checks = 0;

    always #50 clk = ~clk;

    // buffers A and B with data one cycle after the index
    always @(posedge clk) begin
        a_data_out <= a_mem[a_index];
        b_data_out <= b_mem[b_index];
    end

    tpu_top #(
        .addr_bits (addr_bits)
    ) u_tpu_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .k          (k),
        .m          (m),
        .n          (n),
        .a_data_out (a_data_out),
        .b_data_out (b_data_out),
        .busy       (busy),
        .a_index    (a_index),
        .b_index    (b_index),
        .c_wr_en    (c_wr_en),
        .c_index    (c_index),
        .c_data_in  (c_data_in)
    );

    bind tpu_top tpu_chk #(.addr_bits(addr_bits)) u_tpu_chk (
        .clk     (clk),
        .rst_n   (rst_n),
        .busy    (busy),
        .c_wr_en (c_wr_en),
        .c_index (c_index)
    );

    function automatic int ceil_tiles(input int size);
        return (size + dim - 1) / dim;
    endfunction

    // only the last block of A may be short
    function automatic int rows_in_tile(input int size, input int mb);
        if (mb == ceil_tiles(size) - 1 && size % dim != 0) begin
            return size % dim;
        end
        return dim;
    endfunction

    function automatic int draw_elem(input int extremes);
        logic [31:0] r;
        r = $urandom;
        if (extremes != 0) begin
            return (r[0] == 1'b1) ? 127 : -128;
        end
        return int'($signed(r[7:0]));
    endfunction

    task automatic fill_buffers(input int idx);
        int kl;
        int mt;
        int nt;
        kl = k_tab[idx];
        mt = ceil_tiles(m_tab[idx]);
        nt = ceil_tiles(n_tab[idx]);
        // background tied to the full address
        for (int i = 0; i < depth; i++) begin
            a_mem[i] = 32'(i) * 32'h9e37_79b9;
            b_mem[i] = ~(32'(i) * 32'h85eb_ca6b);
            c_mem[i] = '0;
        end
        for (int r = 0; r < mt * dim; r++) begin
            for (int kk = 0; kk < kl; kk++) begin
                a_el[r][kk] = draw_elem(ext_tab[idx]);
            end
        end
        for (int kk = 0; kk < kl; kk++) begin
            for (int c = 0; c < nt * dim; c++) begin
                b_el[kk][c] = draw_elem(ext_tab[idx]);
            end
        end
        // lane 0 sits in the top byte
        for (int kk = 0; kk < kl; kk++) begin
            for (int i = 0; i < dim; i++) begin
                for (int mb = 0; mb < mt; mb++) begin
                    a_mem[mb * kl + kk][(dim-1-i)*8 +: 8] = 8'(a_el[mb*dim+i][kk]);
                end
                for (int nb = 0; nb < nt; nb++) begin
                    b_mem[nb * kl + kk][(dim-1-i)*8 +: 8] = 8'(b_el[kk][nb*dim+i]);
                end
            end
        end
    endtask

    task automatic run_case(input int idx);
        int kl;
        int mt;
        int nt;
        int w;
        int col;
        int exp_v;
        int act_v;
        int cyc;
        int expect_writes;
        int wr_count;
        bit seen_busy;
        bit done;
        kl = k_tab[idx];
        mt = ceil_tiles(m_tab[idx]);
        nt = ceil_tiles(n_tab[idx]);
        fill_buffers(idx);
        wr_count = 0;
        cyc = 0;
        seen_busy = 1'b0;
        done = 1'b0;
        @(posedge clk);
        k <= tpu_pkg::dim_t'(kl);
        m <= tpu_pkg::dim_t'(m_tab[idx]);
        n <= tpu_pkg::dim_t'(n_tab[idx]);
        in_valid <= 1'b1;
        while (!done) begin
            @(posedge clk);
            // second request with other sizes that must be dropped
            if (pulse_tab[idx] != 0 && cyc == 4) begin
                in_valid <= 1'b1;
                k <= 8'd2;
                m <= 8'd1;
                n <= 8'd1;
            end else begin
                in_valid <= 1'b0;
            end
            @(negedge clk);
            cyc++;
            if (busy) begin
                seen_busy = 1'b1;
            end
            if (c_wr_en) begin
                checks++;
                if (int'(c_index) != wr_count) begin
                    $display("** Error: %s: c_index expected %0d, actual %0d",
                             name_tab[idx], wr_count, c_index);
                    proto_errs++;
                end
                c_mem[c_index] = c_data_in;
                wr_count++;
            end
            if (seen_busy && !busy) begin
                done = 1'b1;
            end
        end
        expect_writes = 0;
        for (int mb = 0; mb < mt; mb++) begin
            expect_writes += nt * rows_in_tile(m_tab[idx], mb);
        end
        checks++;
        if (wr_count != expect_writes) begin
            $display("** Error: %s: write count expected %0d, actual %0d",
                     name_tab[idx], expect_writes, wr_count);
            proto_errs++;
        end
        // nb outer, mb inner, row innermost
        w = 0;
        for (int nb = 0; nb < nt; nb++) begin
            for (int mb = 0; mb < mt; mb++) begin
                for (int r = 0; r < rows_in_tile(m_tab[idx], mb); r++) begin
                    for (int j = 0; j < dim; j++) begin
                        col = nb * dim + j;
                        if (col < n_tab[idx]) begin
                            exp_v = 0;
                            for (int kk = 0; kk < kl; kk++) begin
                                exp_v += a_el[mb*dim+r][kk] * b_el[kk][col];
                            end
                            act_v = $signed(c_mem[w][(dim-1-j)*32 +: 32]);
                            checks++;
                            if (act_v != exp_v) begin
                                $display("** Error: %s: C[%0d][%0d] expected %0d, actual %0d",
                                         name_tab[idx], mb*dim+r, col, exp_v, act_v);
                                value_errs++;
                            end
                        end
                    end
                    w++;
                end
            end
        end
    endtask

    initial begin : watchdog
        int limit;
        limit = 10;
        for (int i = 0; i < ncases; i++) begin
            limit += 2 * ceil_tiles(m_tab[i]) * ceil_tiles(n_tab[i]) * (k_tab[i] + 12);
        end
        repeat (limit) @(posedge clk);
        $display("timeout: the jobs did not finish within %0d cycles", limit);
        $display("Result: FAILED");
        $finish;
    end

    initial begin : main
        void'($urandom(32'hc0cc));
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        checks += 2;
        if (busy !== 1'b0) begin
            $display("** Error: after_reset: busy expected 0, actual %b", busy);
            proto_errs++;
        end
        if (c_wr_en !== 1'b0) begin
            $display("** Error: after_reset: c_wr_en expected 0, actual %b", c_wr_en);
            proto_errs++;
        end
        for (int i = 0; i < ncases; i++) begin
            run_case(i);
        end
        $display("checks: %0d, value errors: %0d, protocol errors: %0d",
                 checks, value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
tpu_pkg.sv
job_if.sv
array_ctrl_if.sv
job_config.sv
tile_sequencer.sv
skew_loader.sv
mac_pe.sv
systolic_array.sv
tpu_top.sv
tpu_chk.sv
tb_tpu.sv

// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f files.f --top-module tb_tpu -o tb_tpu > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_tpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi

exit 0
